// ==== hdl/procPkg.sv ====
//--------------------------------------------------
// Shared types, opcodes and constants of the
// 16-bit pipelined core
//--------------------------------------------------
package procPkg;

   // Data words, instructions and byte addresses
   typedef logic [15:0] word_t;

   // Register numbers
   typedef logic [2:0] regIdx_t;

   // Opcode field, instruction bits 15 to 12
   typedef logic [3:0] opcode_t;

   localparam opcode_t OP_NOP  = 4'd0;
   localparam opcode_t OP_ADD  = 4'd1;
   localparam opcode_t OP_SUB  = 4'd2;
   localparam opcode_t OP_AND  = 4'd3;
   localparam opcode_t OP_XOR  = 4'd4;
   localparam opcode_t OP_ADDI = 4'd5;
   localparam opcode_t OP_LBI  = 4'd6;
   localparam opcode_t OP_LD   = 4'd7;
   localparam opcode_t OP_ST   = 4'd8;
   localparam opcode_t OP_BEQZ = 4'd9;
   localparam opcode_t OP_J    = 4'd10;
   localparam opcode_t OP_HALT = 4'd11;   // Codes above this are illegal

   // Byte step between instructions
   localparam word_t PC_STEP = 16'd2;

   localparam word_t RESET_PC = 16'd0;

   // Size of the general register file
   localparam int NUM_REGS = 8;

   // Fetch control
   typedef enum logic {
      running,
      stopped
   } fetchState_t;

endpackage

// ==== hdl/regFile.sv ====
//--------------------------------------------------
// Eight-entry register file, two read ports,
// one write port with write-through
//--------------------------------------------------
`timescale 1ns/1ps

module regFile (
   input  logic             clk,
   input  logic             rstN,
   input  procPkg::regIdx_t rdAddrA,
   input  procPkg::regIdx_t rdAddrB,
   output procPkg::word_t   rdDataA,
   output procPkg::word_t   rdDataB,
   input  logic             wrEn,
   input  procPkg::regIdx_t wrAddr,
   input  procPkg::word_t   wrData
);
   import procPkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Same-cycle write is seen by the reader
   assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== hdl/fetch.sv ====
//--------------------------------------------------
// Fetch stage with program counter, redirect and
// stop control, and the IF/ID register
//--------------------------------------------------
`timescale 1ns/1ps

module fetch (
   input  logic           clk,
   input  logic           rstN,
   input  logic           redirect,
   input  procPkg::word_t redirectPc,
   input  logic           stopFetch,
   output procPkg::word_t instrAddr,
   input  procPkg::word_t instr,
   output procPkg::word_t instrFd,
   output procPkg::word_t pcIncFd,
   output logic           validFd
);
   import procPkg::*;

   word_t       pc;
   word_t       pcInc;
   word_t       pcNext;
   fetchState_t fetchState;

   assign instrAddr = pc;
   assign pcInc     = pc + PC_STEP;

   // Redirect wins over the stopped hold
   always_comb begin
      if (redirect) begin
         pcNext = redirectPc;
      end else if (fetchState == stopped) begin
         pcNext = pc;
      end else begin
         pcNext = pcInc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc         <= RESET_PC;
         fetchState <= running;
         validFd    <= 1'b0;
      end else begin
         pc <= pcNext;
         if (stopFetch) fetchState <= stopped;   // Stays until reset
         // Squash the fetched word on redirect, halt or while stopped
         validFd <= !redirect && !stopFetch && (fetchState == running);
      end
   end

   always_ff @(posedge clk) begin
      instrFd <= instr;
      pcIncFd <= pcInc;
   end

endmodule

// ==== hdl/decode.sv ====
//--------------------------------------------------
// Decode stage with field split, immediates,
// register file and the ID/EX register
//--------------------------------------------------
`timescale 1ns/1ps

module decode (
   input  logic             clk,
   input  logic             rstN,
   input  procPkg::word_t   instrFd,
   input  procPkg::word_t   pcIncFd,
   input  logic             validFd,
   input  logic             redirect,
   input  logic             wbEn,
   input  procPkg::regIdx_t wbReg,
   input  procPkg::word_t   wbData,
   output logic             stopFetch,
   output procPkg::opcode_t opDx,
   output procPkg::regIdx_t rdDx,
   output procPkg::word_t   aDx,
   output procPkg::word_t   bDx,
   output procPkg::word_t   immDx,
   output procPkg::word_t   pcIncDx,
   output logic             validDx
);
   import procPkg::*;

   opcode_t op;
   regIdx_t rd;
   regIdx_t rs;
   regIdx_t rt;
   regIdx_t rdAddrB;
   word_t   imm;
   word_t   rdDataA;
   word_t   rdDataB;
   logic    illegal;

   assign op = instrFd[15:12];
   assign rd = instrFd[11:9];
   assign rs = instrFd[8:6];
   assign rt = instrFd[5:3];

   // Sign-extended immediate, width by opcode
   always_comb begin
      case (op)
         OP_LBI:  imm = {{7{instrFd[8]}}, instrFd[8:0]};
         OP_J:    imm = {{4{instrFd[11]}}, instrFd[11:0]};
         default: imm = {{10{instrFd[5]}}, instrFd[5:0]};
      endcase
   end

   // Store data comes from rd
   assign rdAddrB = (op == OP_ST) ? rd : rt;

   assign illegal   = (op > OP_HALT);
   assign stopFetch = validFd && !redirect && ((op == OP_HALT) || illegal);

   regFile u_regFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (rs),
      .rdAddrB (rdAddrB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wrEn    (wbEn),
      .wrAddr  (wbReg),
      .wrData  (wbData)
   );

   always_ff @(posedge clk) begin
      if (!rstN) begin
         validDx <= 1'b0;
      end else begin
         validDx <= validFd && !redirect;   // Second squashed slot
      end
   end

   always_ff @(posedge clk) begin
      opDx    <= op;
      rdDx    <= rd;
      aDx     <= rdDataA;
      bDx     <= rdDataB;
      immDx   <= imm;
      pcIncDx <= pcIncFd;
   end

endmodule

// ==== hdl/execute.sv ====
//--------------------------------------------------
// Execute stage with ALU, branch and jump
// resolution, and the EX/MEM register
//--------------------------------------------------
`timescale 1ns/1ps

module execute (
   input  logic             clk,
   input  logic             rstN,
   input  procPkg::opcode_t opDx,
   input  procPkg::regIdx_t rdDx,
   input  procPkg::word_t   aDx,
   input  procPkg::word_t   bDx,
   input  procPkg::word_t   immDx,
   input  procPkg::word_t   pcIncDx,
   input  logic             validDx,
   output logic             redirect,
   output procPkg::word_t   redirectPc,
   output procPkg::opcode_t opXm,
   output procPkg::regIdx_t rdXm,
   output procPkg::word_t   resultXm,
   output procPkg::word_t   storeDataXm,
   output logic             validXm
);
   import procPkg::*;

   word_t aluOut;

   always_comb begin
      case (opDx)
         OP_ADD:                aluOut = aDx + bDx;
         OP_SUB:                aluOut = aDx - bDx;   // rs minus rt
         OP_AND:                aluOut = aDx & bDx;
         OP_XOR:                aluOut = aDx ^ bDx;
         OP_ADDI, OP_LD, OP_ST: aluOut = aDx + immDx;
         OP_LBI:                aluOut = immDx;
         default:               aluOut = '0;
      endcase
   end

   // Taken J or BEQZ on zero
   assign redirect = validDx &&
                     ((opDx == OP_J) || ((opDx == OP_BEQZ) && (aDx == '0)));
   assign redirectPc = pcIncDx + immDx;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         validXm <= 1'b0;
      end else begin
         validXm <= validDx;
      end
   end

   always_ff @(posedge clk) begin
      opXm        <= opDx;
      rdXm        <= rdDx;
      resultXm    <= aluOut;
      storeDataXm <= bDx;
   end

endmodule

// ==== hdl/memStage.sv ====
//--------------------------------------------------
// Memory stage with data bus, write-back select,
// MEM/WB register and sticky halted and err
//--------------------------------------------------
`timescale 1ns/1ps

module memStage (
   input  logic             clk,
   input  logic             rstN,
   input  procPkg::opcode_t opXm,
   input  procPkg::regIdx_t rdXm,
   input  procPkg::word_t   resultXm,
   input  procPkg::word_t   storeDataXm,
   input  logic             validXm,
   output procPkg::word_t   dataAddr,
   output logic             dataWe,
   output procPkg::word_t   dataWrData,
   input  procPkg::word_t   dataRdData,
   output logic             wbEn,
   output procPkg::regIdx_t wbReg,
   output procPkg::word_t   wbData,
   output logic             halted,
   output logic             err
);
   import procPkg::*;

   logic isLoad;
   logic isStore;
   logic writesReg;
   logic illegal;

   assign isLoad    = validXm && (opXm == OP_LD);
   assign isStore   = validXm && (opXm == OP_ST);
   assign illegal   = validXm && (opXm > OP_HALT);
   assign writesReg = validXm && (opXm inside {OP_ADD, OP_SUB, OP_AND, OP_XOR,
                                               OP_ADDI, OP_LBI, OP_LD});

   // Bus is quiet unless a load or store is here
   assign dataAddr   = (isLoad || isStore) ? resultXm : '0;
   assign dataWe     = isStore;
   assign dataWrData = isStore ? storeDataXm : '0;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wbEn   <= 1'b0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         wbEn <= writesReg;
         if ((validXm && opXm == OP_HALT) || illegal) halted <= 1'b1;
         if (illegal) err <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      wbReg  <= rdXm;
      wbData <= isLoad ? dataRdData : resultXm;
   end

endmodule

// ==== hdl/proc.sv ====
//--------------------------------------------------
// Top level of the five-stage core
//--------------------------------------------------
`timescale 1ns/1ps

module proc (
   input  logic           clk,
   input  logic           rstN,
   output procPkg::word_t instrAddr,
   input  procPkg::word_t instr,
   output procPkg::word_t dataAddr,
   output logic           dataWe,
   output procPkg::word_t dataWrData,
   input  procPkg::word_t dataRdData,
   output logic           halted,
   output logic           err
);
   import procPkg::*;

   // IF/ID
   word_t   instrFd;
   word_t   pcIncFd;
   logic    validFd;

   // ID/EX
   opcode_t opDx;
   regIdx_t rdDx;
   word_t   aDx;
   word_t   bDx;
   word_t   immDx;
   word_t   pcIncDx;
   logic    validDx;

   // EX/MEM
   opcode_t opXm;
   regIdx_t rdXm;
   word_t   resultXm;
   word_t   storeDataXm;
   logic    validXm;

   // Write-back and control
   logic    wbEn;
   regIdx_t wbReg;
   word_t   wbData;
   logic    redirect;
   word_t   redirectPc;
   logic    stopFetch;

   fetch u_fetch (
      .clk(clk), .rstN(rstN),
      .redirect(redirect), .redirectPc(redirectPc), .stopFetch(stopFetch),
      .instrAddr(instrAddr), .instr(instr),
      .instrFd(instrFd), .pcIncFd(pcIncFd), .validFd(validFd)
   );

   decode u_decode (
      .clk(clk), .rstN(rstN),
      .instrFd(instrFd), .pcIncFd(pcIncFd), .validFd(validFd), .redirect(redirect),
      .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .stopFetch(stopFetch),
      .opDx(opDx), .rdDx(rdDx), .aDx(aDx), .bDx(bDx), .immDx(immDx),
      .pcIncDx(pcIncDx), .validDx(validDx)
   );

   execute u_execute (
      .clk(clk), .rstN(rstN),
      .opDx(opDx), .rdDx(rdDx), .aDx(aDx), .bDx(bDx), .immDx(immDx),
      .pcIncDx(pcIncDx), .validDx(validDx),
      .redirect(redirect), .redirectPc(redirectPc),
      .opXm(opXm), .rdXm(rdXm), .resultXm(resultXm), .storeDataXm(storeDataXm),
      .validXm(validXm)
   );

   memStage u_memStage (
      .clk(clk), .rstN(rstN),
      .opXm(opXm), .rdXm(rdXm), .resultXm(resultXm), .storeDataXm(storeDataXm),
      .validXm(validXm),
      .dataAddr(dataAddr), .dataWe(dataWe), .dataWrData(dataWrData),
      .dataRdData(dataRdData),
      .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
      .halted(halted), .err(err)
   );

endmodule

// ==== sim/procTb.sv ====
//--------------------------------------------------
// Directed testbench for the pipelined core with
// instruction and data memory models, program
// builders, store log and watchdog
//--------------------------------------------------
`timescale 1ns/1ps

module procTb;
   import procPkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int RUN_CYCLES   = 300;
   localparam int NUM_TESTS    = 6;
   localparam int WATCHDOG_NS  = NUM_TESTS * (RUN_CYCLES + RESET_CYCLES) * CLK_PERIOD;

   logic  clk;
   logic  rstN;
   word_t instrAddr;
   word_t instr;
   word_t dataAddr;
   logic  dataWe;
   word_t dataWrData;
   word_t dataRdData;
   logic  halted;
   logic  err;

   word_t      imem [256];
   word_t      dmem [256];
   logic [7:0] progLen;
   word_t      logAddr [$];   // Stores seen on the data bus
   word_t      logData [$];
   word_t      expAddr [$];
   word_t      expData [$];
   string      testName;
   int         failCount;
   int         failsAtStart;
   int         testsRun;
   int         testsFailed;

   proc u_proc (
      .clk(clk), .rstN(rstN),
      .instrAddr(instrAddr), .instr(instr),
      .dataAddr(dataAddr), .dataWe(dataWe), .dataWrData(dataWrData),
      .dataRdData(dataRdData),
      .halted(halted), .err(err)
   );

   // Both memories answer in the same cycle
   assign instr      = imem[instrAddr[8:1]];
   assign dataRdData = dmem[dataAddr[8:1]];

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic word_t signExt9(input logic [8:0] v);
      return 16'($signed(v));
   endfunction

   function automatic word_t signExt6(input logic [5:0] v);
      return 16'($signed(v));
   endfunction

   function automatic word_t encReg(input opcode_t op, input regIdx_t rd,
                                    input regIdx_t rs, input regIdx_t rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic word_t encImm(input opcode_t op, input regIdx_t rd,
                                    input regIdx_t rs, input logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic word_t encLbi(input regIdx_t rd, input logic [8:0] imm);
      return {OP_LBI, rd, imm};
   endfunction

   function automatic word_t encJump(input logic [11:0] imm);
      return {OP_J, imm};
   endfunction

   // Nonzero positive value within imm9
   function automatic logic [8:0] randImm9();
      return 9'(($urandom() % 200) + 1);
   endfunction

   // One clock and a data bus sample mid-cycle
   task automatic tick();
      @(posedge clk);
      #1;
      if (rstN && dataWe) begin
         dmem[dataAddr[8:1]] = dataWrData;
         logAddr.push_back(dataAddr);
         logData.push_back(dataWrData);
      end
   endtask

   task automatic emit(input word_t w);
      imem[progLen] = w;
      progLen++;
   endtask

   task automatic emitGap();
      emit({OP_NOP, 12'd0});   // Producer to consumer spacing
      emit({OP_NOP, 12'd0});
   endtask

   task automatic expectStore(input word_t addr, input word_t data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic checkWord(input string what, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("CHECK FAILED test %s, %s: expected %h, actual %h",
                  testName, what, expected, actual);
         failCount++;
      end
   endtask

   task automatic checkFlag(input string what, input logic expected, input logic actual);
      if (expected !== actual) begin
         $display("CHECK FAILED test %s, %s: expected %b, actual %b",
                  testName, what, expected, actual);
         failCount++;
      end
   endtask

   // Reset is held while the program is built
   task automatic beginTest(input string name);
      testName     = name;
      failsAtStart = failCount;
      rstN         = 1'b0;
      for (int i = 0; i < 256; i++) begin
         imem[i[7:0]] = {OP_NOP, 12'd0};
         dmem[i[7:0]] = {i[7:0], ~i[7:0]};
      end
      progLen = '0;
      logAddr.delete();
      logData.delete();
      expAddr.delete();
      expData.delete();
   endtask

   task automatic releaseReset();
      repeat (RESET_CYCLES) tick();
      rstN = 1'b1;
   endtask

   task automatic waitHalted();
      int cycles;
      cycles = 0;
      while (!halted && cycles < RUN_CYCLES) begin
         tick();
         cycles++;
      end
      if (!halted) begin
         $display("ERROR test %s: core did not halt within %0d cycles", testName, RUN_CYCLES);
         failCount++;
      end
      repeat (4) tick();   // Room for a stray late store
   endtask

   task automatic compareStores();
      int n;
      n = (logAddr.size() < expAddr.size()) ? logAddr.size() : expAddr.size();
      for (int i = 0; i < n; i++) begin
         checkWord($sformatf("store %0d address", i), expAddr[i], logAddr[i]);
         checkWord($sformatf("store %0d data", i), expData[i], logData[i]);
      end
      if (expAddr.size() > logAddr.size()) begin
         $display("ERROR test %s: %0d expected store(s) never happened",
                  testName, expAddr.size() - logAddr.size());
         failCount++;
      end else if (logAddr.size() > expAddr.size()) begin
         $display("ERROR test %s: %0d store(s) happened that should not have",
                  testName, logAddr.size() - expAddr.size());
         failCount++;
      end
   endtask

   task automatic endTest();
      testsRun++;
      if (failCount == failsAtStart) begin
         $display("test %s: ok", testName);
      end else begin
         testsFailed++;
         $display("test %s: %0d error(s)", testName, failCount - failsAtStart);
      end
   endtask

   task automatic testAlu();
      logic [8:0] a9;
      logic [8:0] b9;
      logic [5:0] k6;
      word_t      a;
      word_t      b;
      beginTest("alu");
      a9 = 9'($urandom());
      b9 = 9'($urandom());
      k6 = 6'($urandom());
      a  = signExt9(a9);
      b  = signExt9(b9);
      emit(encLbi(3'd1, a9));
      emit(encLbi(3'd2, b9));
      emitGap();
      emit(encReg(OP_ADD, 3'd3, 3'd1, 3'd2));
      emit(encReg(OP_SUB, 3'd4, 3'd1, 3'd2));
      emit(encReg(OP_AND, 3'd5, 3'd1, 3'd2));
      emit(encReg(OP_XOR, 3'd6, 3'd1, 3'd2));
      emit(encImm(OP_ADDI, 3'd7, 3'd1, k6));
      emit(encImm(OP_ST, 3'd3, 3'd0, 6'd2));   // r0 is still zero
      emit(encImm(OP_ST, 3'd4, 3'd0, 6'd4));
      emit(encImm(OP_ST, 3'd5, 3'd0, 6'd6));
      emit(encImm(OP_ST, 3'd6, 3'd0, 6'd8));
      emit(encImm(OP_ST, 3'd7, 3'd0, 6'd10));
      emit({OP_HALT, 12'd0});
      expectStore(16'd2, a + b);
      expectStore(16'd4, a - b);
      expectStore(16'd6, a & b);
      expectStore(16'd8, a ^ b);
      expectStore(16'd10, a + signExt6(k6));
      releaseReset();
      waitHalted();
      compareStores();
      endTest();
   endtask

   task automatic testLoad();
      word_t x;
      word_t y;
      beginTest("load");
      x = 16'($urandom());
      y = 16'($urandom());
      dmem[8'd10] = x;   // Byte address 20
      dmem[8'd11] = y;
      emit(encImm(OP_LD, 3'd1, 3'd0, 6'd20));
      emit(encImm(OP_LD, 3'd2, 3'd0, 6'd22));
      emitGap();
      emit(encReg(OP_ADD, 3'd3, 3'd1, 3'd2));
      emitGap();
      emit(encImm(OP_ST, 3'd3, 3'd0, 6'd24));
      emit({OP_HALT, 12'd0});
      expectStore(16'd24, x + y);
      releaseReset();
      waitHalted();
      compareStores();
      endTest();
   endtask

   task automatic testBranch();
      logic [8:0] v9;
      beginTest("branch");
      v9 = randImm9();
      emit(encLbi(3'd1, v9));
      emitGap();
      emit(encImm(OP_BEQZ, 3'd0, 3'd0, 6'd4));   // Taken to index 6
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd30));    // Squashed markers
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd28));
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd26));
      emit(encImm(OP_BEQZ, 3'd0, 3'd1, 6'd4));   // Falls through on nonzero r1
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd20));
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd18));
      emit({OP_HALT, 12'd0});
      expectStore(16'd26, signExt9(v9));
      expectStore(16'd20, signExt9(v9));
      expectStore(16'd18, signExt9(v9));
      releaseReset();
      waitHalted();
      compareStores();
      endTest();
   endtask

   task automatic testJumpHalt();
      logic [8:0] v9;
      word_t      holdPc;
      beginTest("jump_halt");
      v9 = randImm9();
      emit(encLbi(3'd1, v9));
      emit(encJump(12'd2));
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd30));   // Skipped
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd28));
      emit({OP_HALT, 12'd0});
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd26));
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd24));
      expectStore(16'd28, signExt9(v9));
      releaseReset();
      waitHalted();
      checkFlag("halted", 1'b1, halted);
      checkFlag("err", 1'b0, err);
      holdPc = instrAddr;
      repeat (20) begin
         tick();
         checkWord("instrAddr held", holdPc, instrAddr);
      end
      compareStores();
      endTest();
   endtask

   task automatic testIllegal();
      logic [8:0] v9;
      beginTest("illegal");
      v9 = randImm9();
      emit(encLbi(3'd1, v9));
      emitGap();
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd26));
      emit({4'd13, 12'd0});
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd30));
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd28));
      expectStore(16'd26, signExt9(v9));
      releaseReset();
      waitHalted();
      checkFlag("halted", 1'b1, halted);
      checkFlag("err", 1'b1, err);
      compareStores();
      endTest();
   endtask

   task automatic testResetMidRun();
      beginTest("reset_mid_run");
      emit(encLbi(3'd1, randImm9()));
      emitGap();
      emit(encImm(OP_ST, 3'd1, 3'd0, 6'd2));
      emit(encJump(12'hFFC));   // Endless loop back to the store
      releaseReset();
      repeat (30) tick();
      checkFlag("stores before reset", 1'b1, logAddr.size() > 0);
      rstN = 1'b0;
      releaseReset();
      checkWord("instrAddr after reset", RESET_PC, instrAddr);
      checkFlag("halted after reset", 1'b0, halted);
      checkFlag("err after reset", 1'b0, err);
      checkFlag("dataWe after reset", 1'b0, dataWe);
      endTest();
   endtask

   initial begin
      rstN        = 1'b0;
      failCount   = 0;
      testsRun    = 0;
      testsFailed = 0;
      void'($urandom(9872));
      tick();
      testAlu();
      testLoad();
      testBranch();
      testJumpHalt();
      testIllegal();
      testResetMidRun();
      $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, failCount);
      if (failCount == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Six full runs plus their resets
   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired before the tests finished");
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== procCore.f ====
hdl/procPkg.sv
hdl/regFile.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memStage.sv
hdl/proc.sv
sim/procTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = procTb
FILELIST  = procCore.f
OBJDIR    = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
